// File: common/tinker_pkg.sv
`default_nettype none

package tinker_pkg;

    typedef logic [63:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t INSTR_BYTES = 64'd4;

    // Encodings follow the Tinker ISA, gaps are opcodes this core does not implement
    typedef enum logic [4:0] {
        OP_AND     = 5'h00,
        OP_OR      = 5'h01,
        OP_XOR     = 5'h02,
        OP_NOT     = 5'h03,
        OP_SHFTR   = 5'h04,
        OP_SHFTRI  = 5'h05,
        OP_SHFTL   = 5'h06,
        OP_SHFTLI  = 5'h07,
        OP_BR      = 5'h08,
        OP_BRRI    = 5'h0a,
        OP_BRNZ    = 5'h0b,
        OP_BRGT    = 5'h0e,
        OP_PRIV    = 5'h0f,
        OP_MOV_MEM = 5'h10,
        OP_MOV_REG = 5'h11,
        OP_MOV_LIT = 5'h12,
        OP_MOV_STR = 5'h13,
        OP_ADD     = 5'h18,
        OP_ADDI    = 5'h19,
        OP_SUB     = 5'h1a,
        OP_SUBI    = 5'h1b
    } opcode_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_src_e;

    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } fetch_t;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic is_branch;
        logic halt;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        opcode_e   opcode;
        reg_addr_t rd;
        word_t     a;
        word_t     b;
        word_t     c;
        word_t     literal;
        ctrl_t     ctrl;
    } de_ex_t;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } src_regs_t;

    typedef struct packed {
        reg_addr_t addr;
        logic      reg_write;
        logic      mem_read;
    } dest_t;

    typedef struct packed {
        fwd_src_e a;
        fwd_src_e b;
        fwd_src_e c;
    } fwd_sel_t;

    typedef struct packed {
        logic      enable;
        reg_addr_t addr;
        word_t     data;
    } writeback_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } dmem_req_t;

    typedef struct packed {
        word_t result;
        word_t mem_addr;
        word_t store_data;
        logic  taken;
        word_t target;
        logic  halt;
    } alu_out_t;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter tinker_pkg::word_t RESET_PC = 64'h2000
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    stall,
    input  tinker_pkg::redirect_t  redirect,
    output tinker_pkg::word_t      imem_addr,
    input  tinker_pkg::instr_t     imem_data,
    output tinker_pkg::fetch_t     fetched
);

    // PRIV with a nonzero literal decodes to no control at all
    localparam tinker_pkg::instr_t NOP_INSTR = {tinker_pkg::OP_PRIV, 15'd0, 12'd1};

    tinker_pkg::word_t pc;

    assign imem_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (!stall) begin
            pc <= pc + tinker_pkg::INSTR_BYTES;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetched <= {64'd0, NOP_INSTR};
        end else if (redirect.taken) begin
            fetched <= {64'd0, NOP_INSTR};
        end else if (!stall) begin
            fetched <= {pc, imem_data};
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipeline_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
    input  tinker_pkg::src_regs_t  src,
    input  tinker_pkg::dest_t      ex_dest,
    input  tinker_pkg::writeback_t wb,
    output tinker_pkg::fwd_sel_t   fwd_sel,
    output logic                   stall
);

    // The younger producer in execute wins over the one in memory/writeback
    function automatic tinker_pkg::fwd_src_e pick_source(
        input tinker_pkg::reg_addr_t  reg_num,
        input tinker_pkg::dest_t      ex_d,
        input tinker_pkg::writeback_t wb_d
    );
        if (ex_d.reg_write && ex_d.addr == reg_num) begin
            return tinker_pkg::FWD_EX;
        end else if (wb_d.enable && wb_d.addr == reg_num) begin
            return tinker_pkg::FWD_MEM;
        end
        return tinker_pkg::FWD_REG;
    endfunction

    always_comb begin
        fwd_sel.a = pick_source(src.rs, ex_dest, wb);
        fwd_sel.b = pick_source(src.rt, ex_dest, wb);
        fwd_sel.c = pick_source(src.rd, ex_dest, wb);
    end

    // Load data only exists in memory/writeback, so a dependent
    // instruction waits one cycle and then takes the FWD_MEM path
    always_comb begin
        stall = ex_dest.mem_read &&
                (ex_dest.addr == src.rs || ex_dest.addr == src.rt);
    end

endmodule

`default_nettype wire

// File: decode/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                     clk,
    input  wire                     reset,
    input  tinker_pkg::writeback_t  wb,
    input  tinker_pkg::reg_addr_t   rs_addr,
    input  tinker_pkg::reg_addr_t   rt_addr,
    input  tinker_pkg::reg_addr_t   rd_addr,
    output tinker_pkg::word_t       rs_data,
    output tinker_pkg::word_t       rt_data,
    output tinker_pkg::word_t       rd_data
);

    tinker_pkg::word_t regs [32];

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign rd_data = regs[rd_addr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable) begin
            regs[wb.addr] <= wb.data;
        end
    end

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  tinker_pkg::fetch_t      fetched,
    input  wire                     stall,
    input  wire                     flush,
    input  tinker_pkg::fwd_sel_t    fwd_sel,
    input  tinker_pkg::word_t       ex_result,
    input  tinker_pkg::writeback_t  wb,
    output tinker_pkg::src_regs_t   src,
    output tinker_pkg::de_ex_t      issued
);

    tinker_pkg::opcode_e opcode;
    tinker_pkg::ctrl_t   ctrl;
    tinker_pkg::word_t   literal;
    tinker_pkg::word_t   rs_data;
    tinker_pkg::word_t   rt_data;
    tinker_pkg::word_t   rd_data;
    tinker_pkg::de_ex_t  next_op;
    logic                use_lit;

    function automatic tinker_pkg::word_t forward(
        input tinker_pkg::fwd_src_e sel,
        input tinker_pkg::word_t    rf_val,
        input tinker_pkg::word_t    ex_val,
        input tinker_pkg::word_t    mem_val
    );
        case (sel)
            tinker_pkg::FWD_EX:  return ex_val;
            tinker_pkg::FWD_MEM: return mem_val;
            default:             return rf_val;
        endcase
    endfunction

    always_comb begin
        opcode  = tinker_pkg::opcode_e'(fetched.instr[31:27]);
        src.rd  = fetched.instr[26:22];
        src.rs  = fetched.instr[21:17];
        src.rt  = fetched.instr[16:12];
        literal = {{52{fetched.instr[11]}}, fetched.instr[11:0]};
        ctrl    = '0;
        use_lit = 1'b0;
        case (opcode)
            tinker_pkg::OP_ADD, tinker_pkg::OP_SUB, tinker_pkg::OP_AND, tinker_pkg::OP_OR,
            tinker_pkg::OP_XOR, tinker_pkg::OP_NOT, tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTL,
            tinker_pkg::OP_MOV_REG: begin
                ctrl.reg_write = 1'b1;
            end
            // Immediate forms read and write the same register
            tinker_pkg::OP_ADDI, tinker_pkg::OP_SUBI, tinker_pkg::OP_SHFTRI,
            tinker_pkg::OP_SHFTLI, tinker_pkg::OP_MOV_LIT: begin
                ctrl.reg_write = 1'b1;
                use_lit        = 1'b1;
                src.rs         = src.rd;
            end
            tinker_pkg::OP_MOV_MEM: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                use_lit        = 1'b1;
            end
            tinker_pkg::OP_MOV_STR: ctrl.mem_write = 1'b1;
            tinker_pkg::OP_BR, tinker_pkg::OP_BRRI, tinker_pkg::OP_BRNZ,
            tinker_pkg::OP_BRGT: ctrl.is_branch = 1'b1;
            tinker_pkg::OP_PRIV: ctrl.halt = (fetched.instr[11:0] == 12'd0);
            default: ;
        endcase
    end

    register_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .wb      (wb),
        .rs_addr (src.rs),
        .rt_addr (src.rt),
        .rd_addr (src.rd),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rd_data (rd_data)
    );

    always_comb begin
        next_op.pc      = fetched.pc;
        next_op.opcode  = opcode;
        next_op.rd      = src.rd;
        next_op.a       = forward(fwd_sel.a, rs_data, ex_result, wb.data);
        next_op.b       = use_lit ? literal : forward(fwd_sel.b, rt_data, ex_result, wb.data);
        next_op.c       = forward(fwd_sel.c, rd_data, ex_result, wb.data);
        next_op.literal = literal;
        next_op.ctrl    = ctrl;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issued <= '0;
        end else if (stall || flush) begin
            issued <= '0;
        end else begin
            issued <= next_op;
        end
    end

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  tinker_pkg::de_ex_t   op,
    output tinker_pkg::alu_out_t out
);

    logic cond;

    always_comb begin
        out        = '0;
        out.target = op.c;
        cond       = 1'b0;
        case (op.opcode)
            tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI: out.result = op.a + op.b;
            tinker_pkg::OP_SUB, tinker_pkg::OP_SUBI: out.result = op.a - op.b;
            tinker_pkg::OP_AND: out.result = op.a & op.b;
            tinker_pkg::OP_OR:  out.result = op.a | op.b;
            tinker_pkg::OP_XOR: out.result = op.a ^ op.b;
            tinker_pkg::OP_NOT: out.result = ~op.a;
            tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI: begin
                out.result = $signed(op.a) >>> op.b[5:0];
            end
            tinker_pkg::OP_SHFTL, tinker_pkg::OP_SHFTLI: begin
                out.result = op.a << op.b[5:0];
            end
            tinker_pkg::OP_MOV_REG: out.result = op.a;
            tinker_pkg::OP_MOV_LIT: out.result = {op.a[63:12], op.b[11:0]};
            tinker_pkg::OP_MOV_MEM: out.mem_addr = op.a + op.literal;
            // Stores address through rd and take their data from rs
            tinker_pkg::OP_MOV_STR: begin
                out.mem_addr   = op.c + op.literal;
                out.store_data = op.a;
            end
            tinker_pkg::OP_BR: cond = 1'b1;
            tinker_pkg::OP_BRRI: begin
                out.target = op.pc + op.literal;
                cond       = 1'b1;
            end
            tinker_pkg::OP_BRNZ: cond = (op.a != 64'd0);
            tinker_pkg::OP_BRGT: cond = ($signed(op.a) > $signed(op.b));
            tinker_pkg::OP_PRIV: out.halt = op.ctrl.halt;
            default: ;
        endcase
        out.taken = op.ctrl.is_branch && cond;
    end

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  tinker_pkg::de_ex_t      issued,
    input  wire                     flush,
    input  tinker_pkg::word_t       dmem_rdata,
    output tinker_pkg::word_t       ex_result,
    output tinker_pkg::dest_t       ex_dest,
    output tinker_pkg::writeback_t  wb,
    output tinker_pkg::redirect_t   redirect,
    output tinker_pkg::dmem_req_t   dmem_req,
    output logic                    hlt
);

    tinker_pkg::alu_out_t  alu_o;
    tinker_pkg::alu_out_t  em_alu;
    tinker_pkg::ctrl_t     em_ctrl;
    tinker_pkg::reg_addr_t em_rd;

    alu u_alu (
        .op  (issued),
        .out (alu_o)
    );

    assign ex_result = alu_o.result;
    assign ex_dest   = {issued.rd, issued.ctrl.reg_write, issued.ctrl.mem_read};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            em_alu  <= '0;
            em_ctrl <= '0;
            em_rd   <= '0;
        end else if (flush) begin
            em_alu  <= '0;
            em_ctrl <= '0;
            em_rd   <= '0;
        end else begin
            em_alu  <= alu_o;
            em_ctrl <= issued.ctrl;
            em_rd   <= issued.rd;
        end
    end

    assign dmem_req = {em_alu.mem_addr, em_alu.store_data, em_ctrl.mem_write};
    assign redirect = {em_alu.taken, em_alu.target};
    assign hlt      = em_alu.halt;

    always_comb begin
        wb.enable = em_ctrl.reg_write;
        wb.addr   = em_rd;
        wb.data   = em_ctrl.mem_read ? dmem_rdata : em_alu.result;
    end

endmodule

`default_nettype wire

// File: verilog/tinker_core.sv
`timescale 1ns/1ps
`default_nettype none

module tinker_core #(
    parameter tinker_pkg::word_t RESET_PC = 64'h2000
) (
    input  wire                    clk,
    input  wire                    reset,
    output tinker_pkg::word_t      imem_addr,
    input  tinker_pkg::instr_t     imem_data,
    output tinker_pkg::dmem_req_t  dmem_req,
    input  tinker_pkg::word_t      dmem_rdata,
    output logic                   hlt
);

    tinker_pkg::fetch_t     fetched;
    tinker_pkg::de_ex_t     issued;
    tinker_pkg::src_regs_t  src;
    tinker_pkg::fwd_sel_t   fwd_sel;
    tinker_pkg::word_t      ex_result;
    tinker_pkg::dest_t      ex_dest;
    tinker_pkg::writeback_t wb;
    tinker_pkg::redirect_t  redirect;
    logic                   stall;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .fetched   (fetched)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .fetched   (fetched),
        .stall     (stall),
        .flush     (redirect.taken),
        .fwd_sel   (fwd_sel),
        .ex_result (ex_result),
        .wb        (wb),
        .src       (src),
        .issued    (issued)
    );

    pipeline_control u_control (
        .src     (src),
        .ex_dest (ex_dest),
        .wb      (wb),
        .fwd_sel (fwd_sel),
        .stall   (stall)
    );

    execute_stage u_execute (
        .clk        (clk),
        .reset      (reset),
        .issued     (issued),
        .flush      (redirect.taken),
        .dmem_rdata (dmem_rdata),
        .ex_result  (ex_result),
        .ex_dest    (ex_dest),
        .wb         (wb),
        .redirect   (redirect),
        .dmem_req   (dmem_req),
        .hlt        (hlt)
    );

endmodule

`default_nettype wire

// File: sim/tinker_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tinker_mem_model #(
    parameter tinker_pkg::word_t BASE = 64'h2000
) (
    input  wire                    clk,
    input  tinker_pkg::word_t      imem_addr,
    output tinker_pkg::instr_t     imem_data,
    input  tinker_pkg::dmem_req_t  dmem_req,
    output tinker_pkg::word_t      dmem_rdata
);

    // PRIV with literal 1 does nothing, so unused program space is harmless
    localparam tinker_pkg::instr_t NOP_INSTR = {tinker_pkg::OP_PRIV, 15'd0, 12'd1};

    tinker_pkg::instr_t    prog [256];
    tinker_pkg::word_t     data [512];
    tinker_pkg::dmem_req_t store_log [$];
    tinker_pkg::word_t     imem_index;

    function automatic tinker_pkg::word_t fill_word(input tinker_pkg::word_t addr);
        return (addr * 64'h9e3779b97f4a7c15) ^ {addr[31:0], ~addr[31:0]};
    endfunction

    initial begin
        for (int i = 0; i < 512; i++) begin
            data[i] = fill_word(tinker_pkg::word_t'(i) << 3);
        end
        for (int i = 0; i < 256; i++) begin
            prog[i] = NOP_INSTR;
        end
    end

    assign imem_index = (imem_addr - BASE) >> 2;
    assign imem_data  = (imem_index < 64'd256) ? prog[imem_index[7:0]] : NOP_INSTR;
    assign dmem_rdata = data[dmem_req.addr[11:3]];

    always @(posedge clk) begin
        if (dmem_req.write) begin
            data[dmem_req.addr[11:3]] <= dmem_req.wdata;
            store_log.push_back(dmem_req);
        end
    end

endmodule

`default_nettype wire

// File: sim/tinker_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tinker_core_tb;

    localparam tinker_pkg::word_t RESET_PC = 64'h2000;
    localparam int NUM_TESTS   = 5;
    localparam int CYCLE_LIMIT = 200 * NUM_TESTS;

    logic                  clk;
    logic                  reset;
    tinker_pkg::word_t     imem_addr;
    tinker_pkg::instr_t    imem_data;
    tinker_pkg::dmem_req_t dmem_req;
    tinker_pkg::word_t     dmem_rdata;
    logic                  hlt;

    int                    errors;
    int                    cycle_count;
    logic [31:0]           lfsr_state;
    tinker_pkg::instr_t    prog [$];
    tinker_pkg::dmem_req_t expected [$];
    tinker_pkg::word_t     model_regs [32];
    tinker_pkg::word_t     model_mem [tinker_pkg::word_t];

    tinker_core #(.RESET_PC(RESET_PC)) u_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .hlt        (hlt)
    );

    tinker_mem_model #(.BASE(RESET_PC)) u_mem (
        .clk        (clk),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the core did not halt within %0d cycles, %0d errors so far",
                     CYCLE_LIMIT, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic tinker_pkg::word_t take_bits(input int n);
        tinker_pkg::word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic tinker_pkg::instr_t encode(input tinker_pkg::opcode_e op,
            input tinker_pkg::reg_addr_t rd, input tinker_pkg::reg_addr_t rs,
            input tinker_pkg::reg_addr_t rt, input logic [11:0] lit);
        return {op, rd, rs, rt, lit};
    endfunction

    // Result rules for the register-writing ALU opcodes
    function automatic tinker_pkg::word_t expect_alu(input tinker_pkg::opcode_e op,
            input tinker_pkg::word_t a, input tinker_pkg::word_t b);
        case (op)
            tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI:     return a + b;
            tinker_pkg::OP_SUB, tinker_pkg::OP_SUBI:     return a - b;
            tinker_pkg::OP_AND:                          return a & b;
            tinker_pkg::OP_OR:                           return a | b;
            tinker_pkg::OP_XOR:                          return a ^ b;
            tinker_pkg::OP_NOT:                          return ~a;
            tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI: return $signed(a) >>> b[5:0];
            tinker_pkg::OP_SHFTL, tinker_pkg::OP_SHFTLI: return a << b[5:0];
            tinker_pkg::OP_MOV_REG:                      return a;
            tinker_pkg::OP_MOV_LIT:                      return {a[63:12], b[11:0]};
            default:                                     return '0;
        endcase
    endfunction

    function automatic tinker_pkg::opcode_e pick_alu_op(input int idx);
        case (idx)
            0:       return tinker_pkg::OP_ADD;
            1:       return tinker_pkg::OP_ADDI;
            2:       return tinker_pkg::OP_SUB;
            3:       return tinker_pkg::OP_SUBI;
            4:       return tinker_pkg::OP_AND;
            5:       return tinker_pkg::OP_OR;
            6:       return tinker_pkg::OP_XOR;
            7:       return tinker_pkg::OP_NOT;
            8:       return tinker_pkg::OP_SHFTR;
            9:       return tinker_pkg::OP_SHFTRI;
            10:      return tinker_pkg::OP_SHFTL;
            11:      return tinker_pkg::OP_SHFTLI;
            12:      return tinker_pkg::OP_MOV_REG;
            default: return tinker_pkg::OP_MOV_LIT;
        endcase
    endfunction

    function automatic tinker_pkg::word_t current_pc();
        return RESET_PC + tinker_pkg::word_t'(4 * prog.size());
    endfunction

    task automatic check_word(input string name, input tinker_pkg::word_t got,
            input tinker_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input tinker_pkg::dmem_req_t got,
            input tinker_pkg::dmem_req_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic start_program();
        prog.delete();
        expected.delete();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
    endtask

    task automatic emit_alu(input tinker_pkg::opcode_e op, input tinker_pkg::reg_addr_t rd,
            input tinker_pkg::reg_addr_t rs, input tinker_pkg::reg_addr_t rt,
            input logic [11:0] lit);
        logic              imm;
        tinker_pkg::word_t a;
        tinker_pkg::word_t b;
        imm = op inside {tinker_pkg::OP_ADDI, tinker_pkg::OP_SUBI, tinker_pkg::OP_SHFTRI,
                         tinker_pkg::OP_SHFTLI, tinker_pkg::OP_MOV_LIT};
        a = imm ? model_regs[rd] : model_regs[rs];
        b = imm ? {{52{lit[11]}}, lit} : model_regs[rt];
        model_regs[rd] = expect_alu(op, a, b);
        prog.push_back(encode(op, rd, imm ? rd : rs, rt, lit));
    endtask

    // Stores address through r0, which no test writes
    task automatic emit_store(input tinker_pkg::reg_addr_t rs, input logic [11:0] off,
            input logic reached);
        tinker_pkg::dmem_req_t r;
        r.addr  = {52'd0, off};
        r.wdata = model_regs[rs];
        r.write = 1'b1;
        prog.push_back(encode(tinker_pkg::OP_MOV_STR, 5'd0, rs, 5'd0, off));
        if (reached) begin
            expected.push_back(r);
            model_mem[r.addr] = r.wdata;
        end
    endtask

    task automatic emit_load(input tinker_pkg::reg_addr_t rd, input logic [11:0] off);
        model_regs[rd] = model_mem[{52'd0, off}];
        prog.push_back(encode(tinker_pkg::OP_MOV_MEM, rd, 5'd0, 5'd0, off));
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        u_mem.store_log.delete();
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic run_program(input string name);
        prog.push_back(encode(tinker_pkg::OP_PRIV, 5'd0, 5'd0, 5'd0, 12'd0));
        for (int i = 0; i < 256; i++) begin
            u_mem.prog[i] = (i < prog.size()) ? prog[i] :
                encode(tinker_pkg::OP_PRIV, 5'd0, 5'd0, 5'd0, 12'd1);
        end
        apply_reset();
        while (!hlt) begin
            @(negedge clk);
        end
        if (u_mem.store_log.size() != expected.size()) begin
            errors++;
            $display("Test %s logged %0d stores where %0d were expected", name,
                     u_mem.store_log.size(), expected.size());
        end
        for (int i = 0; i < expected.size() && i < u_mem.store_log.size(); i++) begin
            check_req({name, " dmem_req"}, u_mem.store_log[i], expected[i]);
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        check_word("imem_addr", imem_addr, RESET_PC);
        check_word("hlt", tinker_pkg::word_t'(hlt), '0);
        check_word("dmem_req.write", tinker_pkg::word_t'(dmem_req.write), '0);
    endtask

    // Each pair of ops runs back to back and both results are stored after it,
    // so operands pass through the execute and the memory forwarding paths
    task automatic test_alu_chain();
        tinker_pkg::reg_addr_t rd;
        tinker_pkg::reg_addr_t prev1;
        tinker_pkg::reg_addr_t prev2;
        start_program();
        prev1 = 5'd1;
        prev2 = 5'd2;
        emit_alu(tinker_pkg::OP_MOV_LIT, 5'd1, 5'd1, 5'd0, 12'(take_bits(12)));
        emit_alu(tinker_pkg::OP_MOV_LIT, 5'd2, 5'd2, 5'd0, 12'(take_bits(12)));
        for (int i = 0; i < 24; i++) begin
            rd = 5'(take_bits(3) + 1);
            // A destination other than the previous one keeps the first result of a pair
            if (rd == prev1) begin
                rd = 5'(rd % 8 + 1);
            end
            emit_alu(pick_alu_op(i % 14), rd, prev1, prev2, 12'(take_bits(12)));
            if (i % 2 == 1) begin
                emit_store(prev1, 12'(12'h100 + 8 * (i - 1)), 1'b1);
                emit_store(rd, 12'(12'h100 + 8 * i), 1'b1);
            end
            prev2 = prev1;
            prev1 = rd;
        end
        run_program("alu_chain");
    endtask

    task automatic test_load_use();
        start_program();
        emit_alu(tinker_pkg::OP_MOV_LIT, 5'd10, 5'd10, 5'd0, 12'(take_bits(12)));
        emit_alu(tinker_pkg::OP_SHFTLI, 5'd10, 5'd10, 5'd0, 12'd20);
        emit_store(5'd10, 12'h200, 1'b1);
        emit_load(5'd11, 12'h200);
        emit_alu(tinker_pkg::OP_ADD, 5'd12, 5'd11, 5'd11, 12'd0);
        emit_store(5'd12, 12'h208, 1'b1);
        emit_store(5'd11, 12'h210, 1'b1);
        emit_load(5'd13, 12'h208);
        emit_store(5'd13, 12'h218, 1'b1);
        run_program("load_use");
    endtask

    // Three stores sit in each branch shadow, a marker store sits at the target
    task automatic branch_case(input tinker_pkg::opcode_e op, input tinker_pkg::reg_addr_t rs,
            input tinker_pkg::reg_addr_t rt, input logic taken, input int k);
        tinker_pkg::word_t target;
        target = current_pc() + 64'd16 + 64'd16;
        emit_alu(tinker_pkg::OP_AND, 5'd20, 5'd0, 5'd0, 12'd0);
        emit_alu(tinker_pkg::OP_MOV_LIT, 5'd20, 5'd20, 5'd0, 12'd1);
        emit_alu(tinker_pkg::OP_SHFTLI, 5'd20, 5'd20, 5'd0, 12'd13);
        emit_alu(tinker_pkg::OP_ADDI, 5'd20, 5'd20, 5'd0, 12'(target - RESET_PC));
        prog.push_back(encode(op, 5'd20, rs, rt, 12'd16));
        for (int j = 0; j < 3; j++) begin
            emit_store(5'd21, 12'(12'h400 + 32 * k + 8 * j), !taken);
        end
        emit_store(5'd21, 12'(12'h300 + 8 * k), 1'b1);
    endtask

    task automatic test_branches();
        start_program();
        emit_alu(tinker_pkg::OP_MOV_LIT, 5'd21, 5'd21, 5'd0, 12'h5a3);
        branch_case(tinker_pkg::OP_BR, 5'd0, 5'd0, 1'b1, 0);
        branch_case(tinker_pkg::OP_BRRI, 5'd0, 5'd0, 1'b1, 1);
        branch_case(tinker_pkg::OP_BRNZ, 5'd21, 5'd0, 1'b1, 2);
        branch_case(tinker_pkg::OP_BRNZ, 5'd0, 5'd0, 1'b0, 3);
        branch_case(tinker_pkg::OP_BRGT, 5'd21, 5'd0, 1'b1, 4);
        branch_case(tinker_pkg::OP_BRGT, 5'd0, 5'd21, 1'b0, 5);
        run_program("branches");
    endtask

    task automatic test_halt();
        start_program();
        emit_alu(tinker_pkg::OP_MOV_LIT, 5'd5, 5'd5, 5'd0, 12'h7c1);
        emit_store(5'd5, 12'h500, 1'b1);
        prog.push_back(encode(tinker_pkg::OP_PRIV, 5'd0, 5'd0, 5'd0, 12'd1));
        emit_alu(tinker_pkg::OP_ADDI, 5'd5, 5'd5, 5'd0, 12'd3);
        emit_store(5'd5, 12'h508, 1'b1);
        emit_store(5'd5, 12'h510, 1'b1);
        run_program("halt");
        // The fill behind the program does not halt, so hlt lasts a single cycle
        @(negedge clk);
        check_word("hlt", tinker_pkg::word_t'(hlt), 64'd0);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        errors      = 0;
        cycle_count = 0;
        lfsr_state  = 32'hdd8a;
        @(negedge clk);
        test_reset_state();
        test_alu_chain();
        test_load_use();
        test_branches();
        test_halt();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tinker_core.f
common/tinker_pkg.sv
verilog/fetch_stage.sv
verilog/pipeline_control.sv
decode/register_file.sv
decode/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
verilog/tinker_core.sv
sim/tinker_mem_model.sv
sim/tinker_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f tinker_core.f --top-module tinker_core_tb -o tinker_sim

./obj_dir/tinker_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
